// ==== design/dbg_pkg.sv ====
package dbg_pkg;

	//////////////////////////////
	// datapath sizes
	//////////////////////////////

	localparam int word_w       = 32;
	localparam int byte_w       = 8;
	localparam int num_regs     = 8;
	localparam int reg_idx_w    = 3;
	localparam int imem_depth   = 32;
	localparam int imem_addr_w  = 5;

	// eight registers then the pc
	localparam int bucket_words = 9;
	localparam int bucket_w     = bucket_words * word_w;
	localparam int bucket_bytes = 36;
	localparam int bucket_idx_w = $clog2(bucket_bytes);

	//////////////////////////////
	// uart framing
	//////////////////////////////

	// bit time chosen short for simulation
	localparam int clks_per_bit = 16;
	localparam int clk_cnt_w    = $clog2(clks_per_bit);
	// start + data + stop
	localparam int frame_bits   = byte_w + 2;
	localparam int bit_cnt_w    = $clog2(frame_bits);

	//////////////////////////////
	// host commands
	//////////////////////////////

	localparam logic [byte_w-1:0] cmd_load = 8'h4c;
	localparam logic [byte_w-1:0] cmd_run  = 8'h52;
	localparam logic [byte_w-1:0] cmd_step = 8'h53;

	//////////////////////////////
	// instruction format
	//////////////////////////////

	localparam int op_w   = 4;
	localparam int op_lsb = 28;
	localparam int rd_lsb = 24;
	localparam int rs_lsb = 20;
	localparam int rt_lsb = 16;
	localparam int imm_w  = 16;

	localparam logic [op_w-1:0] op_nop  = 4'd0;
	localparam logic [op_w-1:0] op_li   = 4'd1;
	localparam logic [op_w-1:0] op_add  = 4'd2;
	localparam logic [op_w-1:0] op_sub  = 4'd3;
	localparam logic [op_w-1:0] op_xor  = 4'd4;
	localparam logic [op_w-1:0] op_halt = 4'd15;

endpackage

// ==== design/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        rx,
	output logic [dbg_pkg::byte_w-1:0]  rx_data,
	output logic                        rx_done
);
	import dbg_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} rx_state_t;

	rx_state_t              state;
	logic [1:0]             rx_sync;
	logic [clk_cnt_w-1:0]   clk_cnt;
	logic [bit_cnt_w-1:0]   bit_cnt;

	// two flop synchronizer on the line
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], rx};
		end
	end

	//////////////////////////////
	// receive fsm
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= st_idle;
			clk_cnt <= '0;
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end else begin
			// done is a single cycle pulse
			rx_done <= 1'b0;
			case (state)
				st_idle: begin
					clk_cnt <= '0;
					bit_cnt <= '0;
					// falling edge means a start bit
					if (!rx_sync[1]) begin
						state <= st_start;
					end
				end
				st_start: begin
					// half a bit to land mid start bit
					if (clk_cnt == clk_cnt_w'(clks_per_bit / 2 - 1)) begin
						clk_cnt <= '0;
						// glitch, back to idle
						state   <= rx_sync[1] ? st_idle : st_data;
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				st_data: begin
					if (clk_cnt == clk_cnt_w'(clks_per_bit - 1)) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == bit_cnt_w'(byte_w - 1)) begin
							state <= st_stop;
						end
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				st_stop: begin
					if (clk_cnt == clk_cnt_w'(clks_per_bit - 1)) begin
						clk_cnt <= '0;
						state   <= st_idle;
						// bad stop bit drops the frame
						rx_done <= rx_sync[1];
					end else begin
						clk_cnt <= clk_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// lsb arrives first so shift in from the top
	always_ff @(posedge clk) begin
		if (state == st_data && clk_cnt == clk_cnt_w'(clks_per_bit - 1)) begin
			rx_data <= {rx_sync[1], rx_data[byte_w-1:1]};
		end
	end

endmodule

// ==== design/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        tx_start,
	input  logic [dbg_pkg::byte_w-1:0]  tx_data,
	output logic                        tx,
	output logic                        tx_done
);
	import dbg_pkg::*;

	logic                   busy;
	logic [frame_bits-1:0]  shreg;
	logic [clk_cnt_w-1:0]   clk_cnt;
	logic [bit_cnt_w-1:0]   bit_cnt;

	// line idles high through the all ones shift register
	assign tx = shreg[0];

	//////////////////////////////
	// frame shifter
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy    <= 1'b0;
			shreg   <= '1;
			clk_cnt <= '0;
			bit_cnt <= '0;
			tx_done <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			if (!busy) begin
				clk_cnt <= '0;
				bit_cnt <= '0;
				if (tx_start) begin
					// stop, data, start
					shreg <= {1'b1, tx_data, 1'b0};
					busy  <= 1'b1;
				end
			end else if (clk_cnt == clk_cnt_w'(clks_per_bit - 1)) begin
				clk_cnt <= '0;
				// refill with idle level
				shreg   <= {1'b1, shreg[frame_bits-1:1]};
				if (bit_cnt == bit_cnt_w'(frame_bits - 1)) begin
					// end of stop bit
					busy    <= 1'b0;
					tx_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== design/debug_ctrl.sv ====
`timescale 1ns/1ps

module debug_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic [dbg_pkg::byte_w-1:0]      rx_data,
	input  logic                            rx_done,
	input  logic                            halted,
	input  logic                            load_ack,
	input  logic                            dump_ack,
	output logic                            load_req,
	output logic [dbg_pkg::imem_addr_w:0]   load_count,
	output logic                            dump_req,
	output logic                            run_en,
	output logic                            step_en,
	output logic                            clear_core
);
	import dbg_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_get_count,
		st_loading,
		st_clear,
		st_running,
		st_step,
		st_dump,
		st_wait_ack_low
	} ctrl_state_t;

	ctrl_state_t state;
	logic        count_ok;

	// accepted word counts 1 to 32
	assign count_ok = (rx_data != '0) && (rx_data <= byte_w'(imem_depth));

	// core controls decoded from state
	assign clear_core = (state == st_clear);
	assign run_en     = (state == st_running);
	assign step_en    = (state == st_step);

	//////////////////////////////
	// command sequencer
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= st_idle;
			load_req   <= 1'b0;
			dump_req   <= 1'b0;
			load_count <= '0;
		end else begin
			case (state)
				st_idle: begin
					// unknown commands fall through
					if (rx_done) begin
						case (rx_data)
							cmd_load: state <= st_get_count;
							cmd_run:  state <= st_clear;
							cmd_step: state <= st_step;
							default:  state <= st_idle;
						endcase
					end
				end
				st_get_count: begin
					if (rx_done) begin
						// bad count aborts the load
						if (count_ok) begin
							load_count <= rx_data[imem_addr_w:0];
							state      <= st_loading;
						end else begin
							state <= st_idle;
						end
					end
				end
				st_loading: begin
					// raise req, drop it once ack arrives
					if (!load_req && !load_ack) begin
						load_req <= 1'b1;
					end else if (load_req && load_ack) begin
						load_req <= 1'b0;
						state    <= st_wait_ack_low;
					end
				end
				st_clear: begin
					state <= st_running;
				end
				st_running: begin
					// leave one cycle after halt shows up
					if (halted) begin
						state <= st_dump;
					end
				end
				st_step: begin
					state <= st_dump;
				end
				st_dump: begin
					if (!dump_req && !dump_ack) begin
						dump_req <= 1'b1;
					end else if (dump_req && dump_ack) begin
						dump_req <= 1'b0;
						state    <= st_wait_ack_low;
					end
				end
				st_wait_ack_low: begin
					// four phase close, ack must fall first
					if (!load_ack && !dump_ack) begin
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

// ==== design/inst_loader.sv ====
`timescale 1ns/1ps

module inst_loader (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            load_req,
	input  logic [dbg_pkg::imem_addr_w:0]   load_count,
	input  logic [dbg_pkg::byte_w-1:0]      rx_data,
	input  logic                            rx_done,
	output logic                            load_ack,
	output logic                            imem_we,
	output logic [dbg_pkg::imem_addr_w-1:0] imem_addr,
	output logic [dbg_pkg::word_w-1:0]      imem_wdata
);
	import dbg_pkg::*;

	logic [1:0]             byte_cnt;
	logic [imem_addr_w:0]   word_cnt;
	logic                   take;

	// only bytes inside an open request
	assign take = load_req && !load_ack && rx_done;

	// word assembly, lsb byte first
	always_ff @(posedge clk) begin
		if (take) begin
			imem_wdata <= {rx_data, imem_wdata[word_w-1:byte_w]};
		end
	end

	//////////////////////////////
	// byte and word counting
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n || !load_req) begin
			byte_cnt  <= '0;
			word_cnt  <= '0;
			imem_we   <= 1'b0;
			imem_addr <= '0;
			load_ack  <= 1'b0;
		end else begin
			imem_we <= 1'b0;
			if (take) begin
				byte_cnt <= byte_cnt + 1'b1;
				// fourth byte completes a word
				if (byte_cnt == 2'd3) begin
					imem_we   <= 1'b1;
					imem_addr <= word_cnt[imem_addr_w-1:0];
					word_cnt  <= word_cnt + 1'b1;
				end
			end
			// ack after the last write
			if (imem_we && word_cnt == load_count) begin
				load_ack <= 1'b1;
			end
		end
	end

endmodule

// ==== design/bucket_sender.sv ====
`timescale 1ns/1ps

module bucket_sender (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            dump_req,
	input  logic [dbg_pkg::bucket_w-1:0]    bucket,
	input  logic                            tx_done,
	output logic                            dump_ack,
	output logic                            tx_start,
	output logic [dbg_pkg::byte_w-1:0]      tx_data
);
	import dbg_pkg::*;

	logic                       active;
	logic [bucket_idx_w-1:0]    idx;
	logic [bucket_w-1:0]        snap;
	logic                       first;

	// first cycle of a fresh request
	assign first = dump_req && !active && !dump_ack;

	// byte picked from the snapshot, reg0 lsb first
	assign tx_data = snap[idx * byte_w +: byte_w];

	// frozen copy so the core state cannot move mid dump
	always_ff @(posedge clk) begin
		if (first) begin
			snap <= bucket;
		end
	end

	//////////////////////////////
	// byte sequencing
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			active   <= 1'b0;
			idx      <= '0;
			dump_ack <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (first) begin
				active   <= 1'b1;
				idx      <= '0;
				tx_start <= 1'b1;
			end else if (active && tx_done) begin
				if (idx == bucket_idx_w'(bucket_bytes - 1)) begin
					// 36th frame out
					active   <= 1'b0;
					dump_ack <= 1'b1;
				end else begin
					idx      <= idx + 1'b1;
					tx_start <= 1'b1;
				end
			end
			// release once request drops
			if (!dump_req) begin
				dump_ack <= 1'b0;
			end
		end
	end

endmodule

// ==== design/tiny_core.sv ====
`timescale 1ns/1ps

module tiny_core (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            run_en,
	input  logic                            step_en,
	input  logic                            clear_core,
	input  logic                            imem_we,
	input  logic [dbg_pkg::imem_addr_w-1:0] imem_addr,
	input  logic [dbg_pkg::word_w-1:0]      imem_wdata,
	output logic [dbg_pkg::bucket_w-1:0]    bucket,
	output logic                            halted,
	output logic [dbg_pkg::byte_w-1:0]      led
);
	import dbg_pkg::*;

	logic [word_w-1:0]      imem [imem_depth];
	logic [word_w-1:0]      regs [num_regs];
	logic [word_w-1:0]      pc;
	logic [word_w-1:0]      instr;
	logic [op_w-1:0]        op;
	logic [reg_idx_w-1:0]   rd;
	logic [reg_idx_w-1:0]   rs;
	logic [reg_idx_w-1:0]   rt;
	logic [imm_w-1:0]       imm;
	logic                   exec;

	// program store, written by the loader only
	always_ff @(posedge clk) begin
		if (imem_we) begin
			imem[imem_addr] <= imem_wdata;
		end
	end

	//////////////////////////////
	// fetch and decode
	//////////////////////////////

	assign instr = imem[pc[imem_addr_w-1:0]];
	assign op    = instr[op_lsb +: op_w];
	assign rd    = instr[rd_lsb +: reg_idx_w];
	assign rs    = instr[rs_lsb +: reg_idx_w];
	assign rt    = instr[rt_lsb +: reg_idx_w];
	assign imm   = instr[imm_w-1:0];
	assign exec  = (run_en || step_en) && !halted;

	//////////////////////////////
	// execute and write back
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n || clear_core) begin
			pc     <= '0;
			halted <= 1'b0;
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (exec) begin
			// halt keeps pc on the halt word
			if (op == op_halt) begin
				halted <= 1'b1;
			end else begin
				pc <= pc + 1'b1;
			end
			case (op)
				op_li:   regs[rd] <= {{(word_w - imm_w){1'b0}}, imm};
				op_add:  regs[rd] <= regs[rs] + regs[rt];
				op_sub:  regs[rd] <= regs[rs] - regs[rt];
				op_xor:  regs[rd] <= regs[rs] ^ regs[rt];
				// nop, halt and unknown codes write nothing
				default: ;
			endcase
		end
	end

	// bucket layout reg0 in the low word, pc on top
	always_comb begin
		for (int i = 0; i < num_regs; i++) begin
			bucket[i * word_w +: word_w] = regs[i];
		end
		bucket[num_regs * word_w +: word_w] = pc;
	end

	assign led = regs[0][byte_w-1:0];

endmodule

// ==== design/debug_top.sv ====
`timescale 1ns/1ps

module debug_top (
	input  logic                        clk100mhz,
	input  logic                        rst_n,
	input  logic                        rx,
	output logic                        tx,
	output logic [dbg_pkg::byte_w-1:0]  led
);
	import dbg_pkg::*;

	// uart side
	logic [byte_w-1:0]      rx_data;
	logic                   rx_done;
	logic [byte_w-1:0]      tx_data;
	logic                   tx_start;
	logic                   tx_done;

	// handshakes
	logic                   load_req;
	logic                   load_ack;
	logic [imem_addr_w:0]   load_count;
	logic                   dump_req;
	logic                   dump_ack;

	// core side
	logic                   run_en;
	logic                   step_en;
	logic                   clear_core;
	logic                   halted;
	logic [bucket_w-1:0]    bucket;
	logic                   imem_we;
	logic [imem_addr_w-1:0] imem_addr;
	logic [word_w-1:0]      imem_wdata;

	//////////////////////////////
	// serial link
	//////////////////////////////

	uart_rx u_uart_rx (
		.clk     (clk100mhz),
		.rst_n   (rst_n),
		.rx      (rx),
		.rx_data (rx_data),
		.rx_done (rx_done)
	);

	uart_tx u_uart_tx (
		.clk      (clk100mhz),
		.rst_n    (rst_n),
		.tx_start (tx_start),
		.tx_data  (tx_data),
		.tx       (tx),
		.tx_done  (tx_done)
	);

	//////////////////////////////
	// control and datapaths
	//////////////////////////////

	debug_ctrl u_debug_ctrl (
		.clk        (clk100mhz),
		.rst_n      (rst_n),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.halted     (halted),
		.load_ack   (load_ack),
		.dump_ack   (dump_ack),
		.load_req   (load_req),
		.load_count (load_count),
		.dump_req   (dump_req),
		.run_en     (run_en),
		.step_en    (step_en),
		.clear_core (clear_core)
	);

	inst_loader u_inst_loader (
		.clk        (clk100mhz),
		.rst_n      (rst_n),
		.load_req   (load_req),
		.load_count (load_count),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.load_ack   (load_ack),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata)
	);

	bucket_sender u_bucket_sender (
		.clk      (clk100mhz),
		.rst_n    (rst_n),
		.dump_req (dump_req),
		.bucket   (bucket),
		.tx_done  (tx_done),
		.dump_ack (dump_ack),
		.tx_start (tx_start),
		.tx_data  (tx_data)
	);

	// core runs on the same clock, gated by run and step enables
	tiny_core u_tiny_core (
		.clk        (clk100mhz),
		.rst_n      (rst_n),
		.run_en     (run_en),
		.step_en    (step_en),
		.clear_core (clear_core),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.bucket     (bucket),
		.halted     (halted),
		.led        (led)
	);

endmodule

// ==== verification/debug_ctrl_sva.sv ====
`timescale 1ns/1ps

module debug_ctrl_sva (
	input logic clk,
	input logic rst_n,
	input logic load_req,
	input logic load_ack,
	input logic dump_req,
	input logic dump_ack,
	input logic run_en
);

	//////////////////////////////
	// four phase handshakes
	//////////////////////////////

	// req holds until ack
	load_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		load_req && !load_ack |=> load_req)
		else $error("load_req dropped before load_ack");

	dump_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		dump_req && !dump_ack |=> dump_req)
		else $error("dump_req dropped before dump_ack");

	// ack only rises under its req
	load_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(load_ack) |-> load_req)
		else $error("load_ack rose without load_req");

	dump_ack_with_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(dump_ack) |-> dump_req)
		else $error("dump_ack rose without dump_req");

	// core frozen while dumping
	no_run_in_dump: assert property (@(posedge clk) disable iff (!rst_n)
		!(run_en && dump_req))
		else $error("run_en high during dump_req");

endmodule

bind debug_ctrl debug_ctrl_sva debug_ctrl_sva_inst (
	.clk      (clk),
	.rst_n    (rst_n),
	.load_req (load_req),
	.load_ack (load_ack),
	.dump_req (dump_req),
	.dump_ack (dump_ack),
	.run_en   (run_en)
);

// ==== verification/debug_top_tb.sv ====
`timescale 1ns/1ps

module debug_top_tb;
	import dbg_pkg::*;

	localparam int clk_period = 8;
	localparam int num_tests  = 6;
	localparam int num_junk   = 5;
	// extra time over the serial traffic for reset and core cycles
	localparam int margin_ns  = 50000;

	// entry kinds
	localparam int k_load_run = 0;
	localparam int k_step     = 1;
	localparam int k_junk_run = 2;
	localparam int k_reload   = 3;

	logic               clk;
	logic               rst_n;
	logic               rx;
	logic               tx;
	logic [byte_w-1:0]  led;

	//////////////////////////////
	// test table
	//////////////////////////////

	// op mask bit 0 li, bit 1 add, bit 2 sub, bit 3 xor
	int                 tab_kind  [num_tests] = '{k_step, k_load_run, k_junk_run,
		k_load_run, k_reload, k_step};
	int                 tab_count [num_tests] = '{6, 12, 0, 32, 5, 4};
	logic [3:0]         tab_ops   [num_tests] = '{4'b1111, 4'b1111, 4'b0000,
		4'b1111, 4'b0011, 4'b1101};
	logic [2:0]         tab_regs  [num_tests] = '{3'b111, 3'b111, 3'b000,
		3'b011, 3'b111, 3'b001};
	// ignored bytes ending in a load with a zero count
	logic [byte_w-1:0]  junk_bytes [num_junk] = '{8'h00, 8'hff, 8'h41, cmd_load, 8'h00};

	logic [31:0]        rng = 32'hb569_1aa4;
	logic [word_w-1:0]  prog [imem_depth];
	logic [word_w-1:0]  dump_w [bucket_words];
	logic [word_w-1:0]  last_dump [bucket_words];
	int                 tx_low_cnt;
	int                 fail_count;

	// reference model state
	logic [word_w-1:0]  m_imem [imem_depth];
	logic [word_w-1:0]  m_regs [num_regs];
	logic [word_w-1:0]  m_pc;
	logic               m_halted;

	debug_top debug_top_inst (
		.clk100mhz (clk),
		.rst_n     (rst_n),
		.rx        (rx),
		.tx        (tx),
		.led       (led)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(clk_period / 2) clk = ~clk;
		end
	end

	// low cycles on tx to spot any unexpected frame
	initial begin
		tx_low_cnt = 0;
	end

	always @(negedge clk) begin
		if (tx === 1'b0) begin
			tx_low_cnt <= tx_low_cnt + 1;
		end
	end

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic flag_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		fail_count++;
		$display("FAIL %0t ns: %s got %h expected %h", $time, name, got, exp);
		$display("TEST FAILED");
		$fatal(1, "stopping at first mismatch");
	endtask

	task automatic abort_run(input string msg);
		fail_count++;
		$display("%0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1, "stopping on protocol error");
	endtask

	function automatic string word_name(input int i);
		if (i < num_regs) begin
			return $sformatf("reg%0d", i);
		end else begin
			return "pc";
		end
	endfunction

	//////////////////////////////
	// random program source
	//////////////////////////////

	function automatic logic [31:0] xorshift32();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [3:0] pick_op(input logic [3:0] mask);
		logic [31:0] r;
		logic [3:0]  op;
		op = op_nop;
		for (int tries = 0; tries < 64; tries++) begin
			r = xorshift32();
			if (mask[r[1:0]]) begin
				case (r[1:0])
					2'd0: op = op_li;
					2'd1: op = op_add;
					2'd2: op = op_sub;
					default: op = op_xor;
				endcase
				break;
			end
		end
		return op;
	endfunction

	// n words with halt as the last one
	task automatic build_program(input int n, input logic [3:0] ops, input logic [2:0] rmask);
		logic [3:0]  op;
		logic [31:0] r;
		for (int i = 0; i < n - 1; i++) begin
			op = pick_op(ops);
			r  = xorshift32();
			prog[i] = {op, 1'b0, r[26:24] & rmask, 1'b0, r[22:20] & rmask,
				1'b0, r[18:16] & rmask, r[15:0]};
		end
		prog[n-1] = {op_halt, 28'h0};
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	function automatic void model_reset();
		m_pc     = '0;
		m_halted = 1'b0;
		for (int i = 0; i < num_regs; i++) begin
			m_regs[i] = '0;
		end
	endfunction

	// one instruction or nothing when halted
	function automatic void model_exec();
		logic [word_w-1:0] w;
		logic [3:0]        op;
		logic [2:0]        rd;
		logic [2:0]        rs;
		logic [2:0]        rt;
		if (m_halted) begin
			return;
		end
		w  = m_imem[m_pc[4:0]];
		op = w[31:28];
		rd = w[26:24];
		rs = w[22:20];
		rt = w[18:16];
		case (op)
			op_li:   m_regs[rd] = {16'h0, w[15:0]};
			op_add:  m_regs[rd] = m_regs[rs] + m_regs[rt];
			op_sub:  m_regs[rd] = m_regs[rs] - m_regs[rt];
			op_xor:  m_regs[rd] = m_regs[rs] ^ m_regs[rt];
			default: ;
		endcase
		if (op == op_halt) begin
			m_halted = 1'b1;
		end else begin
			m_pc = m_pc + 1;
		end
	endfunction

	//////////////////////////////
	// host uart side
	//////////////////////////////

	// called right after a rising edge
	task automatic drive_bit(input logic b);
		#1;
		rx = b;
		repeat (clks_per_bit) @(posedge clk);
	endtask

	task automatic send_byte(input logic [byte_w-1:0] b);
		@(posedge clk);
		drive_bit(1'b0);
		for (int i = 0; i < byte_w; i++) begin
			drive_bit(b[i]);
		end
		drive_bit(1'b1);
	endtask

	// tx sampled on the falling edge half a clock after it moves
	task automatic recv_byte(output logic [byte_w-1:0] b);
		@(negedge clk);
		while (tx !== 1'b0) begin
			@(negedge clk);
		end
		repeat (clks_per_bit / 2) @(negedge clk);
		assert (tx === 1'b0) else abort_run("tx start bit did not last to mid-bit");
		for (int i = 0; i < byte_w; i++) begin
			repeat (clks_per_bit) @(negedge clk);
			b[i] = tx;
		end
		repeat (clks_per_bit) @(negedge clk);
		assert (tx === 1'b1) else abort_run("tx frame has no stop bit");
	endtask

	// 36 bytes lsb first into nine words
	task automatic recv_bucket();
		logic [byte_w-1:0] b;
		for (int w = 0; w < bucket_words; w++) begin
			for (int k = 0; k < 4; k++) begin
				recv_byte(b);
				dump_w[w][k * byte_w +: byte_w] = b;
			end
		end
	endtask

	//////////////////////////////
	// command sequences
	//////////////////////////////

	task automatic check_dump();
		for (int i = 0; i < num_regs; i++) begin
			assert (dump_w[i] === m_regs[i])
				else flag_mismatch(word_name(i), dump_w[i], m_regs[i]);
		end
		assert (dump_w[num_regs] === m_pc)
			else flag_mismatch("pc", dump_w[num_regs], m_pc);
		@(negedge clk);
		// led mirrors reg0 low byte
		assert (led === m_regs[0][byte_w-1:0])
			else flag_mismatch("led", {24'h0, led}, {24'h0, m_regs[0][byte_w-1:0]});
		for (int i = 0; i < bucket_words; i++) begin
			last_dump[i] = dump_w[i];
		end
	endtask

	task automatic load_program(input int n);
		send_byte(cmd_load);
		send_byte(byte_w'(n));
		for (int i = 0; i < n; i++) begin
			for (int k = 0; k < 4; k++) begin
				send_byte(prog[i][k * byte_w +: byte_w]);
			end
			m_imem[i] = prog[i];
		end
	endtask

	task automatic run_and_check();
		model_reset();
		for (int i = 0; i < 2 * imem_depth && !m_halted; i++) begin
			model_exec();
		end
		fork
			send_byte(cmd_run);
			recv_bucket();
		join
		check_dump();
	endtask

	task automatic step_and_check();
		logic [word_w-1:0] prev [bucket_words];
		logic [word_w-1:0] prev_pc;
		logic              prev_halted;
		logic [3:0]        prev_op;
		for (int i = 0; i < bucket_words; i++) begin
			prev[i] = last_dump[i];
		end
		prev_pc     = m_pc;
		prev_halted = m_halted;
		prev_op     = m_imem[m_pc[4:0]][31:28];
		model_exec();
		fork
			send_byte(cmd_step);
			recv_bucket();
		join
		check_dump();
		if (prev_halted) begin
			// halted core so the dump must repeat
			for (int i = 0; i < bucket_words; i++) begin
				assert (dump_w[i] === prev[i])
					else flag_mismatch(word_name(i), dump_w[i], prev[i]);
			end
		end else if (prev_op != op_halt) begin
			assert (dump_w[num_regs] === prev_pc + 1)
				else flag_mismatch("pc", dump_w[num_regs], prev_pc + 1);
		end
	endtask

	task automatic send_junk();
		int low_before;
		low_before = tx_low_cnt;
		for (int i = 0; i < num_junk; i++) begin
			send_byte(junk_bytes[i]);
		end
		// long enough for a dump to have started
		repeat (2 * frame_bits * clks_per_bit) @(posedge clk);
		assert (tx_low_cnt == low_before)
			else abort_run("tx became active after ignored bytes");
	endtask

	//////////////////////////////
	// watchdog
	//////////////////////////////

	function automatic longint table_bytes();
		longint total;
		total = 0;
		for (int t = 0; t < num_tests; t++) begin
			case (tab_kind[t])
				k_step:     total += 2 + 4 * tab_count[t] + (tab_count[t] + 2) * 37;
				k_junk_run: total += num_junk + 37;
				default:    total += 2 + 4 * tab_count[t] + 37;
			endcase
		end
		return total;
	endfunction

	initial begin
		longint limit_ns;
		limit_ns = table_bytes() * frame_bits * clks_per_bit * clk_period + margin_ns;
		#(limit_ns);
		$display("watchdog expired at %0t ns: run hung and the dump never arrived", $time);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		fail_count = 0;
		rx         = 1'b1;
		rst_n      = 1'b0;
		for (int i = 0; i < bucket_words; i++) begin
			last_dump[i] = '0;
		end
		model_reset();
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
		repeat (5) @(posedge clk);
		for (int t = 0; t < num_tests; t++) begin
			$display("entry %0d kind %0d count %0d", t, tab_kind[t], tab_count[t]);
			case (tab_kind[t])
				k_step: begin
					build_program(tab_count[t], tab_ops[t], tab_regs[t]);
					load_program(tab_count[t]);
					// one extra step lands on the halted core
					for (int s = 0; s < tab_count[t] + 1; s++) begin
						step_and_check();
					end
					run_and_check();
				end
				k_junk_run: begin
					send_junk();
					run_and_check();
				end
				default: begin
					build_program(tab_count[t], tab_ops[t], tab_regs[t]);
					load_program(tab_count[t]);
					run_and_check();
				end
			endcase
		end
		if (fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
design/dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_ctrl.sv
design/inst_loader.sv
design/bucket_sender.sv
design/tiny_core.sv
design/debug_top.sv
verification/debug_ctrl_sva.sv
verification/debug_top_tb.sv
